//--- rtl/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and address width
`define XLEN 32

`define REG_COUNT 32

// instruction memory words, byte addressed by pc
`define IMEM_DEPTH 64

`define BTB_ENTRIES 32

// btb index sits just above the byte offset, tag takes the rest
`define BTB_IDX_W $clog2(`BTB_ENTRIES)
`define BTB_TAG_W (`XLEN - `BTB_IDX_W - 2)

`define PC_STEP 4

`endif

//--- rtl/isa_pkg.sv
`include "core_defines.svh"

package isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;

  // rv32i major opcodes handled by the core
  typedef enum logic [6:0] {
    op_arith     = 7'b0110011,
    op_arith_imm = 7'b0010011,
    op_branch    = 7'b1100011,
    op_jal       = 7'b1101111,
    op_jalr      = 7'b1100111,
    op_system    = 7'b1110011
  } opcode_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_and, alu_or, alu_xor,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu,
    // branch compares
    alu_beq, alu_bne, alu_blt, alu_bge
  } alu_func_e;

endpackage

//--- rtl/pipe_pkg.sv
package pipe_pkg;

  import isa_pkg::*;

  // fetch -> decode
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t pred_pc; // next pc as guessed by fetch
    word_t instr;
  } fetch_t;

  // decode -> execute
  typedef struct packed {
    logic      valid;
    word_t     pc;
    word_t     pred_pc;
    alu_func_e func;
    logic      use_imm;
    logic      is_branch;
    logic      is_jal;
    logic      is_jalr;
    logic      is_ecall;
    logic      reg_write;
    reg_idx_t  rs1;
    reg_idx_t  rs2;
    reg_idx_t  rd;
    word_t     rs1_val;
    word_t     rs2_val;
    word_t     imm;
  } decode_t;

  typedef struct packed {
    logic  valid;
    word_t target;
    logic  update_btb; // taken control flow, entry needs writing
    word_t pc;         // pc of the resolved instruction
  } redirect_t;

  typedef struct packed {
    logic     valid;
    reg_idx_t rd;
    word_t    value;
  } retire_t;

endpackage

//--- rtl/branch_target_buffer.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module branch_target_buffer import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  word_t     lookup_pc,
  output logic      hit,
  output word_t     target,
  input  redirect_t update
);

  localparam int IDX_W = `BTB_IDX_W;
  localparam int TAG_W = `BTB_TAG_W;

  logic [`BTB_ENTRIES-1:0] entry_valid;
  logic [TAG_W-1:0]        entry_tag [`BTB_ENTRIES];
  word_t                   entry_target [`BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx, wr_idx;

  assign rd_idx = lookup_pc[IDX_W+1:2];
  assign wr_idx = update.pc[IDX_W+1:2];

  // lookup is purely combinational
  assign hit    = entry_valid[rd_idx] && (entry_tag[rd_idx] == lookup_pc[`XLEN-1:IDX_W+2]);
  assign target = entry_target[rd_idx];

  always_ff @(posedge clk) begin
    if (reset) begin
      entry_valid <= '0;
    end else if (update.valid && update.update_btb) begin
      entry_valid[wr_idx] <= 1'b1;
    end
  end

  // tag and target payload
  always_ff @(posedge clk) begin
    if (update.valid && update.update_btb) begin
      entry_tag[wr_idx]    <= update.pc[`XLEN-1:IDX_W+2];
      entry_target[wr_idx] <= update.target;
    end
  end

endmodule

//--- rtl/fetch_unit.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module fetch_unit import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      run,
  input  logic      load_en,
  input  word_t     load_addr,
  input  word_t     load_data,
  input  logic      halted,
  input  redirect_t redirect,
  output fetch_t    fetch
);

  localparam int IMEM_AW = $clog2(`IMEM_DEPTH);

  word_t pc;
  word_t pred_pc;
  word_t next_pc;
  word_t btb_target;
  logic  btb_hit;
  word_t imem [`IMEM_DEPTH];

  branch_target_buffer u_btb (
    .clk       (clk),
    .reset     (reset),
    .lookup_pc (pc),
    .hit       (btb_hit),
    .target    (btb_target),
    .update    (redirect)
  );

  // program load only while the core is stopped
  always_ff @(posedge clk) begin
    if (load_en && !run) begin
      imem[load_addr[IMEM_AW+1:2]] <= load_data;
    end
  end

  assign pred_pc = btb_hit ? btb_target : pc + `PC_STEP;
  assign next_pc = redirect.valid ? redirect.target : pred_pc; // execute wins over btb

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= '0;
    end else if (run && !halted) begin
      pc <= next_pc;
    end
  end

  always_comb begin
    fetch.valid   = run && !halted && !redirect.valid;
    fetch.pc      = pc;
    fetch.pred_pc = pred_pc;
    fetch.instr   = imem[pc[IMEM_AW+1:2]];
  end

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module decode_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  fetch_t    fetch,
  input  redirect_t redirect,
  input  logic      halted,
  input  retire_t   retire,
  output decode_t   decoded
);

  fetch_t  ifid;
  decode_t dec;
  word_t   regs [`REG_COUNT];
  word_t   instr;
  logic    uses_rs1, uses_rs2;
  logic    flush;

  assign flush = redirect.valid || halted;
  assign instr = ifid.instr;

  always_ff @(posedge clk) begin
    ifid <= fetch;
    if (reset || flush) ifid.valid <= 1'b0;
  end

  function automatic alu_func_e alu_sel(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? alu_sub : alu_add;
      3'b001:  return alu_sll;
      3'b010:  return alu_slt;
      3'b011:  return alu_sltu;
      3'b100:  return alu_xor;
      3'b101:  return alt ? alu_sra : alu_srl;
      3'b110:  return alu_or;
      default: return alu_and;
    endcase
  endfunction

  // regfile read, bypassing a write landing this same cycle
  function automatic word_t read_reg(input reg_idx_t idx);
    word_t v;
    if (idx == '0) v = '0;
    else if (retire.valid && retire.rd == idx) v = retire.value;
    else v = regs[idx];
    return v;
  endfunction

  always_comb begin
    dec         = '0;
    dec.valid   = ifid.valid;
    dec.pc      = ifid.pc;
    dec.pred_pc = ifid.pred_pc;
    uses_rs1    = 1'b0;
    uses_rs2    = 1'b0;
    case (opcode_e'(instr[6:0]))
      op_arith: begin
        dec.func = alu_sel(instr[14:12], instr[30]);
        dec.reg_write = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      op_arith_imm: begin
        dec.func = alu_sel(instr[14:12], instr[30] && instr[14:12] == 3'b101); // only srai
        dec.use_imm = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm = {{20{instr[31]}}, instr[31:20]};
        uses_rs1 = 1'b1;
      end
      op_branch: begin
        case (instr[14:12])
          3'b001:  dec.func = alu_bne;
          3'b100:  dec.func = alu_blt;
          3'b101:  dec.func = alu_bge;
          default: dec.func = alu_beq;
        endcase
        dec.is_branch = 1'b1;
        dec.imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
      end
      op_jal: begin
        dec.is_jal = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      op_jalr: begin
        dec.is_jalr = 1'b1;
        dec.reg_write = 1'b1;
        dec.imm = {{20{instr[31]}}, instr[31:20]};
        uses_rs1 = 1'b1;
      end
      op_system: dec.is_ecall = 1'b1;
      default: ; // unknown opcode passes as a nop
    endcase
    dec.rs1     = uses_rs1 ? instr[19:15] : '0; // zero index keeps forwarding quiet
    dec.rs2     = uses_rs2 ? instr[24:20] : '0;
    dec.rd      = dec.reg_write ? instr[11:7] : '0;
    dec.rs1_val = read_reg(dec.rs1);
    dec.rs2_val = read_reg(dec.rs2);
  end

  always_ff @(posedge clk) begin
    if (retire.valid && retire.rd != '0) regs[retire.rd] <= retire.value;
  end

  always_ff @(posedge clk) begin
    decoded <= dec;
    if (reset || flush) decoded.valid <= 1'b0;
  end

endmodule

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`include "core_defines.svh"

module execute_stage import isa_pkg::*, pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  decode_t   decoded,
  output redirect_t redirect,
  output logic      halted,
  output retire_t   retire
);

  logic  ex_valid;
  logic  taken;
  logic  ctrl_taken;
  word_t src1, src2;
  word_t op_b;
  word_t alu_out;
  word_t result;
  word_t real_target;
  word_t next_seq;

  // anything still in flight after the ecall is dropped here
  assign ex_valid = decoded.valid && !halted;

  // forward from the retire register, x0 never forwards
  assign src1 = (retire.valid && retire.rd != '0 && retire.rd == decoded.rs1) ?
                retire.value : decoded.rs1_val;
  assign src2 = (retire.valid && retire.rd != '0 && retire.rd == decoded.rs2) ?
                retire.value : decoded.rs2_val;

  assign op_b     = decoded.use_imm ? decoded.imm : src2;
  assign next_seq = decoded.pc + `PC_STEP;

  always_comb begin
    case (decoded.func)
      alu_sub:  alu_out = src1 - op_b;
      alu_and:  alu_out = src1 & op_b;
      alu_or:   alu_out = src1 | op_b;
      alu_xor:  alu_out = src1 ^ op_b;
      alu_sll:  alu_out = src1 << op_b[4:0];
      alu_srl:  alu_out = src1 >> op_b[4:0];
      alu_sra:  alu_out = word_t'($signed(src1) >>> op_b[4:0]);
      alu_slt:  alu_out = {{(`XLEN-1){1'b0}}, $signed(src1) < $signed(op_b)};
      alu_sltu: alu_out = {{(`XLEN-1){1'b0}}, src1 < op_b};
      default:  alu_out = src1 + op_b;
    endcase
  end

  always_comb begin
    case (decoded.func)
      alu_bne: taken = src1 != src2;
      alu_blt: taken = $signed(src1) < $signed(src2);
      alu_bge: taken = $signed(src1) >= $signed(src2);
      default: taken = src1 == src2;
    endcase
  end

  assign ctrl_taken = (decoded.is_branch && taken) || decoded.is_jal || decoded.is_jalr;
  assign result     = (decoded.is_jal || decoded.is_jalr) ? next_seq : alu_out; // link

  always_comb begin
    if (decoded.is_jalr) begin
      real_target = (src1 + decoded.imm) & ~word_t'(1);
    end else if ((decoded.is_branch && taken) || decoded.is_jal) begin
      real_target = decoded.pc + decoded.imm;
    end else begin
      real_target = next_seq;
    end
  end

  // mispredict check, resolved in the same cycle
  always_comb begin
    redirect.valid      = ex_valid && (real_target != decoded.pred_pc);
    redirect.target     = real_target;
    redirect.update_btb = ctrl_taken;
    redirect.pc         = decoded.pc;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      halted <= 1'b0;
    end else if (ex_valid && decoded.is_ecall) begin
      halted <= 1'b1; // sticky until reset
    end
  end

  always_ff @(posedge clk) begin
    retire.rd    <= decoded.rd;
    retire.value <= (decoded.rd != '0) ? result : '0;
    if (reset) retire.valid <= 1'b0;
    else retire.valid <= ex_valid && !decoded.is_ecall;
  end

endmodule

//--- rtl/core_top.sv
`timescale 1ns/1ps

module core_top import isa_pkg::*, pipe_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  logic    run,
  input  logic    load_en,
  input  word_t   load_addr,
  input  word_t   load_data,
  output retire_t retire,
  output logic    halted
);

  fetch_t    fetch;
  decode_t   decoded;
  redirect_t redirect;

  fetch_unit u_fetch (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .halted    (halted),
    .redirect  (redirect),
    .fetch     (fetch)
  );

  decode_stage u_decode (
    .clk      (clk),
    .reset    (reset),
    .fetch    (fetch),
    .redirect (redirect),
    .halted   (halted),
    .retire   (retire),
    .decoded  (decoded)
  );

  execute_stage u_execute (
    .clk      (clk),
    .reset    (reset),
    .decoded  (decoded),
    .redirect (redirect),
    .halted   (halted),
    .retire   (retire)
  );

endmodule

//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
  parameter int RESET_CYCLES = 16
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk; // 4 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

//--- dv/retire_checker.sv
`timescale 1ns/1ps

module retire_checker import isa_pkg::*, pipe_pkg::*; #(
  parameter int MAX_EXP = 64
) (
  input  logic    clk,
  input  logic    reset,
  input  retire_t retire,
  input  logic    halted,
  input  retire_t expected [MAX_EXP],
  input  int      exp_count,
  input  logic    end_check,
  output logic    done,
  output int      error_count
);

  int   next_idx  = 0; // next expected record
  int   errors    = 0;
  logic halt_seen = 1'b0;
  logic finished  = 1'b0;

  assign done        = finished;
  assign error_count = errors;

  // rd 0 retires carry no architectural result
  task automatic compare_retire();
    retire_t want;
    if (next_idx >= exp_count) begin
      $display("extra retire of x%0d = %h after the last expected record", retire.rd,
               retire.value);
      errors++;
    end else begin
      want = expected[next_idx];
      if (retire.rd !== want.rd) begin
        $display("Mismatch retire.rd: expected %h, got %h (record %0d)", want.rd, retire.rd,
                 next_idx);
        errors++;
      end
      if (retire.value !== want.value) begin
        $display("Mismatch retire.value: expected %h, got %h (record %0d)", want.value,
                 retire.value, next_idx);
        errors++;
      end
      next_idx++;
    end
  endtask

  task automatic report_leftovers();
    if (next_idx < exp_count) begin
      $display("missing retires: %0d of %0d expected records never retired",
               exp_count - next_idx, exp_count);
      errors++;
    end
    if (!halt_seen) begin
      $display("the core never raised halted");
      errors++;
    end
    finished = 1'b1;
  endtask

  // sample mid-cycle, away from the edge that updates retire
  always @(negedge clk) begin
    if (!reset && !finished) begin
      if (retire.valid && halt_seen) begin
        $display("an instruction retired after the core had halted");
        errors++;
      end
      if (retire.valid && retire.rd != '0) compare_retire();
      if (halted) halt_seen = 1'b1;
      if (end_check) report_leftovers();
    end
  end

endmodule

//--- dv/tb_top.sv
`timescale 1ns/1ps

module tb_top import isa_pkg::*, pipe_pkg::*; ();

  localparam int    MAX_WORDS = 64;
  localparam int    MAX_EXP   = 64;
  localparam string DATA_FILE = "dv/program_input.txt";

  logic    clk;
  logic    reset;
  logic    run;
  logic    load_en;
  word_t   load_addr;
  word_t   load_data;
  retire_t retire;
  logic    halted;

  word_t   prog_addr [MAX_WORDS];
  word_t   prog_data [MAX_WORDS];
  retire_t expected  [MAX_EXP];
  int      prog_count;
  int      exp_count;
  int      tb_errors;
  int      check_errors;
  logic    end_check;
  logic    check_done;

  clock_gen u_clock (
    .clk   (clk),
    .reset (reset)
  );

  core_top u_dut (
    .clk       (clk),
    .reset     (reset),
    .run       (run),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .retire    (retire),
    .halted    (halted)
  );

  retire_checker #(.MAX_EXP (MAX_EXP)) u_checker (
    .clk         (clk),
    .reset       (reset),
    .retire      (retire),
    .halted      (halted),
    .expected    (expected),
    .exp_count   (exp_count),
    .end_check   (end_check),
    .done        (check_done),
    .error_count (check_errors)
  );

  // P lines go to the program, E lines with a nonzero rd to the expected list
  task automatic read_program();
    int    fd;
    int    n;
    string line;
    string tag;
    word_t a;
    word_t b;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("could not open %s for reading", DATA_FILE);
      tb_errors++;
      return;
    end
    while (!$feof(fd)) begin
      n = $fgets(line, fd);
      if (n > 1) begin
        tag = line.substr(0, 0);
        n   = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, b);
        if (tag == "P" && n == 2 && prog_count < MAX_WORDS) begin
          prog_addr[prog_count] = a;
          prog_data[prog_count] = b;
          prog_count++;
        end else if (tag == "E" && n == 2 && a != '0 && exp_count < MAX_EXP) begin
          expected[exp_count].valid = 1'b1;
          expected[exp_count].rd    = a[4:0];
          expected[exp_count].value = b;
          exp_count++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic load_program();
    int i;
    for (i = 0; i < prog_count; i++) begin
      load_en   <= 1'b1;
      load_addr <= prog_addr[i];
      load_data <= prog_data[i];
      @(posedge clk);
    end
    load_en <= 1'b0;
    @(posedge clk);
  endtask

  initial begin
    int limit;
    int cycles;
    int i;
    run        = 1'b0;
    load_en    = 1'b0;
    load_addr  = '0;
    load_data  = '0;
    end_check  = 1'b0;
    prog_count = 0;
    exp_count  = 0;
    tb_errors  = 0;
    cycles     = 0;
    read_program();
    if (prog_count == 0 || exp_count == 0) begin
      $display("data file gave %0d program words and %0d expected records", prog_count,
               exp_count);
      tb_errors++;
    end
    limit = 20 * exp_count + 200;

    @(posedge clk);
    while (reset) @(posedge clk);
    load_program();
    run <= 1'b1;

    while (!halted && cycles < limit) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) begin
      $display("timeout after %0d cycles without the core halting", limit);
      tb_errors++;
    end

    repeat (8) @(posedge clk); // room for a stray retire after the halt
    end_check <= 1'b1;
    for (i = 0; i < 4 && !check_done; i++) @(posedge clk);
    if (!check_done) begin
      $display("retire checker never finished its closing check");
      tb_errors++;
    end

    $display("errors: %0d total (retire checker %0d, testbench %0d)",
             check_errors + tb_errors, check_errors, tb_errors);
    if (check_errors + tb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- dv/program_input.txt
# P lines hold a byte address and an instruction word in hex
# E lines hold rd and its value in hex in retire order
P 00000000 00500093  # addi x1, x0, 5
P 00000004 ffd00113  # addi x2, x0, -3
P 00000008 402081b3  # sub x3, x1, x2
P 0000000c 40115213  # srai x4, x2, 1
P 00000010 001122b3  # slt x5, x2, x1
P 00000014 00219313  # slli x6, x3, 2
P 00000018 001155b3  # srl x11, x2, x1
P 0000001c 00300393  # addi x7, x0, 3
P 00000020 fff38393  # loop: addi x7, x7, -1
P 00000024 fe039ee3  # bne x7, x0, loop
P 00000028 0080046f  # jal x8, +8
P 0000002c 00100493  # addi x9, x0, 1 skipped by jal
P 00000030 00c40567  # jalr x10, 12(x8)
P 00000034 00200493  # addi x9, x0, 2 skipped by jalr
P 00000038 00000073  # ecall
P 0000003c 00100613  # addi x12, x0, 1 behind the halt
E 01 00000005
E 02 fffffffd
E 03 00000008
E 04 fffffffe
E 05 00000001
E 06 00000020
E 0b 07ffffff
E 07 00000003
E 07 00000002
E 07 00000001
E 07 00000000
E 08 0000002c
E 0a 00000034

//--- build.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/branch_target_buffer.sv
rtl/fetch_unit.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/core_top.sv
dv/clock_gen.sv
dv/retire_checker.sv
dv/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the core testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module tb_top -f build.f -o tb_sim > build.log 2>&1 \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
grep -q "RESULT: FAIL" sim.log && { echo "simulation reported a failure"; exit 1; }
grep -q "RESULT: PASS" sim.log || { echo "no result line found in sim.log"; exit 1; }
exit 0
